/* Bender.yml */
package:
  name: fpu_front_end

sources:
  - files:
      - hw/fpu_pkg.sv
      - hw/fpu_issue.sv
      - hw/fpu_sign_inject.sv
      - hw/fpu_classify.sv
      - hw/fpu_compare.sv
      - hw/fpu_result_mux.sv
      - hw/fpu_top.sv
  - target: test
    files:
      - bench/fpu_tb_clk.sv
      - bench/fpu_chk.sv
      - bench/fpu_tb.sv

/* bench/fpu_chk.sv */
`timescale 1ns/100ps

module fpu_chk (
  input logic i_clk,
  input logic i_rst,
  input logic i_res_valid,
  input logic i_stall,
  input logic i_inflight
);

  // Assertion failures so far
  int fail_count = 0;

  // ============================================================
  // Top-level protocol properties
  // ============================================================
  // Result cycle never stalls
  assert property (@(posedge i_clk) disable iff (i_rst) !(i_res_valid && i_stall))
    else begin
      fail_count++;
      $error("o_valid and o_stall high in the same cycle");
    end

  // Result valid is a single-cycle pulse
  assert property (@(posedge i_clk) disable iff (i_rst) i_res_valid |=> !i_res_valid)
    else begin
      fail_count++;
      $error("o_valid high in two consecutive cycles");
    end

  // Compare in flight keeps the FPU stalled
  assert property (@(posedge i_clk) disable iff (i_rst) i_inflight |-> i_stall)
    else begin
      fail_count++;
      $error("o_inflight_valid high while o_stall is low");
    end

  // No stale result right out of reset
  assert property (@(posedge i_clk) $fell(i_rst) |-> !i_res_valid)
    else begin
      fail_count++;
      $error("o_valid high in the first cycle after reset");
    end

endmodule : fpu_chk

bind fpu_top fpu_chk u_chk (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .i_res_valid(o_valid),
  .i_stall(o_stall),
  .i_inflight(o_inflight_valid)
);

/* bench/fpu_tb.sv */
`timescale 1ns/100ps

module fpu_tb;

  import fpu_pkg::*;

  logic                    clk;
  logic                    rst;
  logic                    valid;
  fpu_op_e                 operation;
  logic [FpWidth-1:0]      operand_a;
  logic [FpWidth-1:0]      operand_b;
  logic [RegAddrWidth-1:0] dest_reg;
  logic [FpWidth-1:0]      result;
  logic                    result_valid;
  logic                    result_to_int;
  logic [RegAddrWidth-1:0] result_dest;
  fp_flags_t               flags;
  logic                    stall;
  logic                    inflight_valid;
  logic [RegAddrWidth-1:0] inflight_dest;
  logic [31:0]             lfsr_state;

  fpu_tb_clk u_clk (.o_clk(clk), .o_rst(rst));

  fpu_top dut (
    .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_operation(operation),
    .i_operand_a(operand_a), .i_operand_b(operand_b), .i_dest_reg(dest_reg),
    .o_result(result), .o_valid(result_valid), .o_result_to_int(result_to_int),
    .o_dest_reg(result_dest), .o_flags(flags), .o_stall(stall),
    .o_inflight_valid(inflight_valid), .o_inflight_dest(inflight_dest)
  );

  // ============================================================
  // Failure reporting and the value check
  // ============================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      fail_run($sformatf("ERROR at %0t ns: %s expected %h actual %h",
                         $time, name, expected, actual));
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  // ============================================================
  // Reference model
  // ============================================================
  function automatic logic is_nan(input logic [31:0] v);
    return (v[30:23] == 8'hff) && (v[22:0] != 0);
  endfunction

  function automatic logic is_snan(input logic [31:0] v);
    return is_nan(v) && !v[22];
  endfunction

  // Signed magnitude mapped onto a number line, both zeros land on 0
  function automatic longint order_key(input logic [31:0] v);
    if (v[31])
      return -longint'(v[30:0]);
    return longint'(v[30:0]);
  endfunction

  function automatic logic [9:0] class_model(input logic [31:0] v);
    int idx;
    if (v[30:23] == 8'hff && v[22:0] == 0)
      idx = v[31] ? 0 : 7;
    else if (v[30:23] == 8'hff)
      idx = v[22] ? 9 : 8;
    else if (v[30:23] == 0 && v[22:0] == 0)
      idx = v[31] ? 3 : 4;
    else if (v[30:23] == 0)
      idx = v[31] ? 2 : 5;
    else
      idx = v[31] ? 1 : 6;
    return 10'b1 << idx;
  endfunction

  // Expected result, flags {nv,dz,of,uf,nx}, integer marking and latency
  task automatic model_op(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                          output logic [31:0] res, output logic [4:0] flg,
                          output logic to_int, output int lat);
    logic   any_nan;
    logic   any_snan;
    logic   a_first;
    longint ka;
    longint kb;
    any_nan = is_nan(a) || is_nan(b);
    any_snan = is_snan(a) || is_snan(b);
    ka = order_key(a);
    kb = order_key(b);
    // -0 sits below +0 for min and max
    a_first = (ka < kb) || (ka == kb && a[31] && !b[31]);
    res = '0;
    flg = '0;
    to_int = 1'b1;
    lat = 4;
    case (op)
      FSGNJ, FSGNJN, FSGNJX: begin
        to_int = 1'b0;
        lat = 3;
        if (op == FSGNJ)
          res = {b[31], a[30:0]};
        else if (op == FSGNJN)
          res = {~b[31], a[30:0]};
        else
          res = {a[31] ^ b[31], a[30:0]};
      end
      FCLASS: begin
        res = {22'b0, class_model(a)};
        lat = 3;
      end
      FEQ: begin
        res[0] = !any_nan && (ka == kb);
        flg[4] = any_snan;
      end
      FLT: begin
        res[0] = !any_nan && (ka < kb);
        flg[4] = any_nan;
      end
      FLE: begin
        res[0] = !any_nan && (ka <= kb);
        flg[4] = any_nan;
      end
      default: begin
        to_int = 1'b0;
        flg[4] = any_snan;
        if (is_nan(a) && is_nan(b))
          res = FpCanonicalNan;
        else if (is_nan(a))
          res = b;
        else if (is_nan(b))
          res = a;
        else if (op == FMIN)
          res = a_first ? a : b;
        else
          res = a_first ? b : a;
      end
    endcase
  endtask

  // ============================================================
  // Driving and waiting
  // ============================================================
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (stall && cycles < 50) begin
      cycles++;
      @(negedge clk);
    end
    if (stall)
      fail_run("timeout: o_stall never dropped");
  endtask

  // Returns at the accepting edge
  task automatic send_op(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] dest);
    wait_idle();
    @(posedge clk);
    valid <= 1'b1;
    operation <= op;
    operand_a <= a;
    operand_b <= b;
    dest_reg <= dest;
    // Stall rises with the request itself
    @(negedge clk);
    check_value("o_stall", 1'b1, stall);
    @(posedge clk);
    valid <= 1'b0;
  endtask

  // Counts edges from acceptance to the result pulse
  task automatic wait_result(output int lat);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!result_valid && cycles < 50) begin
      // Stall holds until the result is registered
      check_value("o_stall", 1'b1, stall);
      cycles++;
      @(negedge clk);
    end
    if (!result_valid)
      fail_run("timeout: o_valid never came");
    lat = cycles;
  endtask

  task automatic run_and_check(input fpu_op_e op, input logic [31:0] a,
                               input logic [31:0] b, input logic [4:0] dest);
    logic [31:0] exp_result;
    logic [4:0]  exp_flags;
    logic        exp_to_int;
    int          exp_lat;
    int          lat;
    send_op(op, a, b, dest);
    wait_result(lat);
    model_op(op, a, b, exp_result, exp_flags, exp_to_int, exp_lat);
    check_value("o_result", exp_result, result);
    check_value("o_flags", exp_flags, flags);
    check_value("o_result_to_int", exp_to_int, result_to_int);
    check_value("o_dest_reg", dest, result_dest);
    check_value("latency", exp_lat, lat);
  endtask

  // Ordered, equal, signed zero and NaN operand pairs
  function automatic logic [63:0] special_pair(input int idx);
    case (idx)
      0: return {32'h3f80_0000, 32'h4000_0000};
      1: return {32'h4000_0000, 32'h3f80_0000};
      2: return {32'hbf80_0000, 32'h3f80_0000};
      3: return {32'hc000_0000, 32'hbf80_0000};
      4: return {32'h3fc0_0000, 32'h3fc0_0000};
      5: return {32'h8000_0000, 32'h0000_0000};
      6: return {32'h0000_0000, 32'h8000_0000};
      7: return {32'h7fc0_0000, 32'h3f80_0000};
      8: return {32'h3f80_0000, 32'h7f80_0001};
      9: return {32'hff80_0005, 32'h7fc0_0000};
      default: return '0;
    endcase
  endfunction

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic test_sign_inject();
    logic [31:0] a;
    logic [31:0] b;
    fpu_op_e     op;
    for (int k = 0; k < 3; k++) begin
      op = (k == 0) ? FSGNJ : (k == 1) ? FSGNJN : FSGNJX;
      for (int n = 0; n < 20; n++) begin
        rand_word(a);
        rand_word(b);
        run_and_check(op, a, b, 5'(n + k));
      end
    end
  endtask

  task automatic test_classify();
    logic [31:0] mag;
    for (int n = 0; n < 6; n++) begin
      // inf, normal, subnormal, zero, sNaN, qNaN
      case (n)
        0: mag = 32'h7f80_0000;
        1: mag = 32'h3f80_0000;
        2: mag = 32'h0000_0400;
        3: mag = 32'h0000_0000;
        4: mag = 32'h7f80_0001;
        default: mag = 32'h7fc0_0000;
      endcase
      run_and_check(FCLASS, mag, '0, 5'(2 * n));
      run_and_check(FCLASS, mag | 32'h8000_0000, '0, 5'(2 * n + 1));
    end
  endtask

  task automatic test_compare();
    logic [63:0] pair;
    for (int n = 0; n < 10; n++) begin
      pair = special_pair(n);
      run_and_check(FEQ, pair[63:32], pair[31:0], 5'(n));
      run_and_check(FLT, pair[63:32], pair[31:0], 5'(n + 10));
      run_and_check(FLE, pair[63:32], pair[31:0], 5'(n + 20));
    end
  endtask

  task automatic test_min_max();
    logic [63:0] pair;
    logic [31:0] a;
    logic [31:0] b;
    for (int n = 0; n < 10; n++) begin
      pair = special_pair(n);
      run_and_check(FMIN, pair[63:32], pair[31:0], 5'(n));
      run_and_check(FMAX, pair[63:32], pair[31:0], 5'(n + 16));
    end
    for (int n = 0; n < 10; n++) begin
      rand_word(a);
      rand_word(b);
      run_and_check(FMIN, a, b, 5'(n + 3));
      run_and_check(FMAX, a, b, 5'(n + 19));
    end
  endtask

  // Second request during a compare must be dropped
  task automatic test_busy();
    int   pulses;
    logic seen_inflight;
    send_op(FEQ, 32'h3f80_0000, 32'h3f80_0000, 5'd7);
    @(posedge clk);
    valid <= 1'b1;
    operation <= FSGNJN;
    dest_reg <= 5'd12;
    // Second request arrives while the FPU is stalled
    @(negedge clk);
    check_value("o_stall", 1'b1, stall);
    @(posedge clk);
    valid <= 1'b0;
    pulses = 0;
    seen_inflight = 1'b0;
    repeat (12) begin
      @(negedge clk);
      if (inflight_valid) begin
        seen_inflight = 1'b1;
        check_value("o_inflight_dest", 5'd7, inflight_dest);
      end
      if (result_valid) begin
        pulses++;
        check_value("o_dest_reg", 5'd7, result_dest);
        check_value("o_result", 32'd1, result);
      end
    end
    check_value("o_inflight_valid", 1'b1, seen_inflight);
    check_value("o_valid pulse count", 1, pulses);
  endtask

  initial begin
    int cycles;
    valid <= 1'b0;
    operation <= FSGNJ;
    operand_a <= '0;
    operand_b <= '0;
    dest_reg <= '0;
    lfsr_state = 32'd41;
    cycles = 0;
    @(negedge clk);
    while (rst && cycles < 64) begin
      cycles++;
      @(negedge clk);
    end
    if (rst)
      fail_run("timeout: reset was never released");
    test_sign_inject();
    test_classify();
    test_compare();
    test_min_max();
    test_busy();
    // Protocol assertions of the bound checker
    if (dut.u_chk.fail_count != 0) begin
      fail_run("protocol assertion failed during the run");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule : fpu_tb

/* bench/fpu_tb_clk.sv */
`timescale 1ns/100ps

module fpu_tb_clk (
  output logic o_clk,
  output logic o_rst
);

  // 100 ns period
  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;
  end

  // Synchronous reset, held for 16 rising edges
  initial begin
    o_rst = 1'b1;
    repeat (16) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule : fpu_tb_clk

/* filelist.f */
hw/fpu_pkg.sv
hw/fpu_issue.sv
hw/fpu_sign_inject.sv
hw/fpu_classify.sv
hw/fpu_compare.sv
hw/fpu_result_mux.sv
hw/fpu_top.sv
bench/fpu_tb_clk.sv
bench/fpu_chk.sv
bench/fpu_tb.sv

/* hw/fpu_classify.sv */
`timescale 1ns/100ps

module fpu_classify (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_start,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_a,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_dest_reg,
  output logic                              o_valid,
  output logic [fpu_pkg::ClassWidth-1:0]    o_result,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_dest_reg
);

  import fpu_pkg::*;

  logic                  sign;
  logic [ExpWidth-1:0]   exponent;
  logic [ManWidth-1:0]   fraction;
  logic                  exp_ones;
  logic                  exp_zero;
  logic                  frac_zero;
  logic [ClassWidth-1:0] mask;

  // Field split
  assign sign = i_operand_a[SignBit];
  assign exponent = i_operand_a[SignBit-1 -: ExpWidth];
  assign fraction = i_operand_a[ManWidth-1:0];
  assign exp_ones = &exponent;
  assign exp_zero = ~|exponent;
  assign frac_zero = ~|fraction;

  // One-hot class mask
  always_comb begin
    mask = '0;
    if (exp_ones && !frac_zero) begin
      // NaN sign is ignored, quiet bit decides
      if (fraction[QuietBit]) mask[ClsQnan] = 1'b1;
      else mask[ClsSnan] = 1'b1;
    end else if (exp_ones) begin
      if (sign) mask[ClsNegInf] = 1'b1;
      else mask[ClsPosInf] = 1'b1;
    end else if (exp_zero && frac_zero) begin
      if (sign) mask[ClsNegZero] = 1'b1;
      else mask[ClsPosZero] = 1'b1;
    end else if (exp_zero) begin
      if (sign) mask[ClsNegSub] = 1'b1;
      else mask[ClsPosSub] = 1'b1;
    end else begin
      if (sign) mask[ClsNegNorm] = 1'b1;
      else mask[ClsPosNorm] = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_start;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      o_result <= mask;
      o_dest_reg <= i_dest_reg;
    end
  end

endmodule : fpu_classify

/* hw/fpu_compare.sv */
`timescale 1ns/100ps

module fpu_compare (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_start,
  input  fpu_pkg::fpu_op_e                  i_operation,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_a,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_b,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_dest_reg,
  output logic                              o_valid,
  output logic [fpu_pkg::FpWidth-1:0]       o_result,
  output logic                              o_to_int,
  output fpu_pkg::fp_flags_t                o_flags,
  output logic                              o_busy,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_dest_reg
);

  import fpu_pkg::*;

  logic                    a_nan, b_nan, a_snan, b_snan;
  logic                    both_zero, a_lt_b, a_eq_b, a_lt_mm;

  // Stage one registers
  logic                    s1_valid;
  fpu_op_e                 s1_op;
  logic [FpWidth-1:0]      s1_a, s1_b;
  logic                    s1_any_nan, s1_any_snan, s1_a_nan, s1_b_nan;
  logic                    s1_eq, s1_lt, s1_lt_mm;
  logic [RegAddrWidth-1:0] s1_dest;

  // Stage two payload
  logic [FpWidth-1:0]      res_d;
  logic                    bit_d, to_int_d, nv_d;
  logic [RegAddrWidth-1:0] s2_dest;

  // ============================================================
  // Stage one, NaN detection and ordering
  // ============================================================
  assign a_nan = (&i_operand_a[SignBit-1 -: ExpWidth]) & (|i_operand_a[ManWidth-1:0]);
  assign b_nan = (&i_operand_b[SignBit-1 -: ExpWidth]) & (|i_operand_b[ManWidth-1:0]);
  assign a_snan = a_nan & ~i_operand_a[QuietBit];
  assign b_snan = b_nan & ~i_operand_b[QuietBit];
  // +0 and -0 compare equal
  assign both_zero = ~|(i_operand_a[SignBit-1:0] | i_operand_b[SignBit-1:0]);
  assign a_eq_b = (i_operand_a == i_operand_b) | both_zero;

  // Sign and magnitude ordering
  always_comb begin
    if (i_operand_a[SignBit] != i_operand_b[SignBit])
      a_lt_b = i_operand_a[SignBit] & ~both_zero;
    else if (i_operand_a[SignBit])
      a_lt_b = i_operand_a[SignBit-1:0] > i_operand_b[SignBit-1:0];
    else
      a_lt_b = i_operand_a[SignBit-1:0] < i_operand_b[SignBit-1:0];
  end

  // Min/max order, -0 below +0
  assign a_lt_mm = a_lt_b | (both_zero & i_operand_a[SignBit] & ~i_operand_b[SignBit]);

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      s1_op <= i_operation;
      s1_a <= i_operand_a;
      s1_b <= i_operand_b;
      s1_a_nan <= a_nan;
      s1_b_nan <= b_nan;
      s1_any_nan <= a_nan | b_nan;
      s1_any_snan <= a_snan | b_snan;
      s1_eq <= a_eq_b;
      s1_lt <= a_lt_b;
      s1_lt_mm <= a_lt_mm;
      s1_dest <= i_dest_reg;
    end
  end

  // ============================================================
  // Stage two, result and flags
  // ============================================================
  always_comb begin
    bit_d = 1'b0;
    to_int_d = 1'b0;
    nv_d = s1_any_snan;
    res_d = '0;
    case (s1_op)
      FEQ: begin
        bit_d = ~s1_any_nan & s1_eq;
        to_int_d = 1'b1;
      end
      FLT: begin
        bit_d = ~s1_any_nan & s1_lt;
        to_int_d = 1'b1;
        nv_d = s1_any_nan;
      end
      FLE: begin
        bit_d = ~s1_any_nan & (s1_lt | s1_eq);
        to_int_d = 1'b1;
        nv_d = s1_any_nan;
      end
      default: begin
        // FMIN and FMAX
        if (s1_a_nan && s1_b_nan) res_d = FpCanonicalNan;
        else if (s1_a_nan) res_d = s1_b;
        else if (s1_b_nan) res_d = s1_a;
        else if (s1_op == FMIN) res_d = s1_lt_mm ? s1_a : s1_b;
        else res_d = s1_lt_mm ? s1_b : s1_a;
      end
    endcase
    if (to_int_d) res_d = {{(FpWidth-1){1'b0}}, bit_d};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_valid <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      s1_valid <= i_start;
      o_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s1_valid) begin
      o_result <= res_d;
      o_to_int <= to_int_d;
      o_flags <= '{nv: nv_d, dz: 1'b0, of: 1'b0, uf: 1'b0, nx: 1'b0};
      s2_dest <= s1_dest;
    end
  end

  // Busy from stage one through the result cycle
  assign o_busy = s1_valid | o_valid;
  // Destination of whichever stage holds the operation
  assign o_dest_reg = s1_valid ? s1_dest : s2_dest;

endmodule : fpu_compare

/* hw/fpu_issue.sv */
`timescale 1ns/100ps

module fpu_issue (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_valid,
  input  fpu_pkg::fpu_op_e                  i_operation,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_a,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_b,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_dest_reg,
  input  logic                              i_result_valid,
  output fpu_pkg::fpu_op_e                  o_operation,
  output logic [fpu_pkg::FpWidth-1:0]       o_operand_a,
  output logic [fpu_pkg::FpWidth-1:0]       o_operand_b,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_dest_reg,
  output logic                              o_start_sgnj,
  output logic                              o_start_class,
  output logic                              o_start_cmp,
  output logic                              o_stall
);

  import fpu_pkg::*;

  logic capture_pending;
  logic active;
  logic start_any;
  logic busy;
  logic accept;
  logic is_sgnj;
  logic is_class;
  logic is_cmp;

  // ============================================================
  // Input capture
  // ============================================================
  assign start_any = o_start_sgnj | o_start_class | o_start_cmp;
  // Active drops in the result cycle so a new request there is taken
  assign busy = active & ~i_result_valid;
  assign accept = i_valid & ~capture_pending & ~start_any & ~busy;

  // Captured request, loaded only on accept
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_operation <= i_operation;
      o_operand_a <= i_operand_a;
      o_operand_b <= i_operand_b;
      o_dest_reg <= i_dest_reg;
    end
  end

  // Unit selection from the captured operation
  always_comb begin
    is_sgnj = 1'b0;
    is_class = 1'b0;
    is_cmp = 1'b0;
    case (o_operation)
      FSGNJ, FSGNJN, FSGNJX: is_sgnj = 1'b1;
      FCLASS: is_class = 1'b1;
      FEQ, FLT, FLE, FMIN, FMAX: is_cmp = 1'b1;
      default: ;
    endcase
  end

  // ============================================================
  // Start strobes and active tracking
  // ============================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      capture_pending <= 1'b0;
      o_start_sgnj <= 1'b0;
      o_start_class <= 1'b0;
      o_start_cmp <= 1'b0;
      active <= 1'b0;
    end else begin
      capture_pending <= accept;
      // Exactly one strobe, the cycle after capture
      o_start_sgnj <= capture_pending & is_sgnj;
      o_start_class <= capture_pending & is_class;
      o_start_cmp <= capture_pending & is_cmp;
      if (i_result_valid) begin
        active <= 1'b0;
      end else if (start_any) begin
        active <= 1'b1;
      end
    end
  end

  // Start cycle is covered too, active is not yet set there
  assign o_stall = (active | i_valid | capture_pending | start_any) & ~i_result_valid;

endmodule : fpu_issue

/* hw/fpu_pkg.sv */
package fpu_pkg;

  // ============================================================
  // Field widths and positions for single precision
  // ============================================================
  localparam int unsigned FpWidth = 32;
  localparam int unsigned ExpWidth = 8;
  localparam int unsigned ManWidth = 23;
  localparam int unsigned SignBit = 31;
  localparam int unsigned QuietBit = 22;

  // Destination register number width
  localparam int unsigned RegAddrWidth = 5;

  // Canonical quiet NaN, positive sign and only the quiet bit set
  localparam logic [FpWidth-1:0] FpCanonicalNan = 32'h7fc0_0000;

  // ============================================================
  // FCLASS mask, bit positions in RISC-V order
  // ============================================================
  localparam int unsigned ClassWidth = 10;
  localparam int unsigned ClsNegInf = 0;
  localparam int unsigned ClsNegNorm = 1;
  localparam int unsigned ClsNegSub = 2;
  localparam int unsigned ClsNegZero = 3;
  localparam int unsigned ClsPosZero = 4;
  localparam int unsigned ClsPosSub = 5;
  localparam int unsigned ClsPosNorm = 6;
  localparam int unsigned ClsPosInf = 7;
  localparam int unsigned ClsSnan = 8;
  localparam int unsigned ClsQnan = 9;

  // Operations handled by this front end
  typedef enum logic [3:0] {
    FSGNJ,
    FSGNJN,
    FSGNJX,
    FCLASS,
    FEQ,
    FLT,
    FLE,
    FMIN,
    FMAX
  } fpu_op_e;

  // Exception flags, same order as fflags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

endpackage : fpu_pkg

/* hw/fpu_result_mux.sv */
`timescale 1ns/100ps

module fpu_result_mux (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_sgnj_valid,
  input  logic [fpu_pkg::FpWidth-1:0]       i_sgnj_result,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_sgnj_dest,
  input  logic                              i_class_valid,
  input  logic [fpu_pkg::ClassWidth-1:0]    i_class_result,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_class_dest,
  input  logic                              i_cmp_valid,
  input  logic [fpu_pkg::FpWidth-1:0]       i_cmp_result,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_cmp_dest,
  input  logic                              i_cmp_to_int,
  input  fpu_pkg::fp_flags_t                i_cmp_flags,
  output logic                              o_valid,
  output logic [fpu_pkg::FpWidth-1:0]       o_result,
  output fpu_pkg::fp_flags_t                o_flags,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_dest_reg,
  output logic                              o_result_to_int
);

  import fpu_pkg::*;

  logic                    any_valid;
  logic [FpWidth-1:0]      result_d;
  fp_flags_t               flags_d;
  logic [RegAddrWidth-1:0] dest_d;
  logic                    to_int_d;

  assign any_valid = i_cmp_valid | i_class_valid | i_sgnj_valid;

  // ============================================================
  // Priority select, compare first
  // ============================================================
  always_comb begin
    flags_d = '0;
    to_int_d = 1'b0;
    if (i_cmp_valid) begin
      result_d = i_cmp_result;
      flags_d = i_cmp_flags;
      dest_d = i_cmp_dest;
      to_int_d = i_cmp_to_int;
    end else if (i_class_valid) begin
      // Class mask goes to an integer register
      result_d = {{(FpWidth-ClassWidth){1'b0}}, i_class_result};
      dest_d = i_class_dest;
      to_int_d = 1'b1;
    end else begin
      result_d = i_sgnj_result;
      dest_d = i_sgnj_dest;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= any_valid;
    end
  end

  // Payload holds between results
  always_ff @(posedge i_clk) begin
    if (any_valid) begin
      o_result <= result_d;
      o_flags <= flags_d;
      o_dest_reg <= dest_d;
      o_result_to_int <= to_int_d;
    end
  end

endmodule : fpu_result_mux

/* hw/fpu_sign_inject.sv */
`timescale 1ns/100ps

module fpu_sign_inject (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_start,
  input  fpu_pkg::fpu_op_e                  i_operation,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_a,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_b,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_dest_reg,
  output logic                              o_valid,
  output logic [fpu_pkg::FpWidth-1:0]       o_result,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_dest_reg
);

  import fpu_pkg::*;

  logic new_sign;

  // Sign source by variant
  always_comb begin
    case (i_operation)
      FSGNJN: new_sign = ~i_operand_b[SignBit];
      FSGNJX: new_sign = i_operand_a[SignBit] ^ i_operand_b[SignBit];
      default: new_sign = i_operand_b[SignBit];
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_start;
    end
  end

  // Magnitude of a passes through untouched
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      o_result <= {new_sign, i_operand_a[SignBit-1:0]};
      o_dest_reg <= i_dest_reg;
    end
  end

endmodule : fpu_sign_inject

/* hw/fpu_top.sv */
`timescale 1ns/100ps

module fpu_top (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_valid,
  input  fpu_pkg::fpu_op_e                  i_operation,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_a,
  input  logic [fpu_pkg::FpWidth-1:0]       i_operand_b,
  input  logic [fpu_pkg::RegAddrWidth-1:0]  i_dest_reg,
  output logic [fpu_pkg::FpWidth-1:0]       o_result,
  output logic                              o_valid,
  output logic                              o_result_to_int,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_dest_reg,
  output fpu_pkg::fp_flags_t                o_flags,
  output logic                              o_stall,
  output logic                              o_inflight_valid,
  output logic [fpu_pkg::RegAddrWidth-1:0]  o_inflight_dest
);

  import fpu_pkg::*;

  // Issue stage outputs
  fpu_op_e                 op_r;
  logic [FpWidth-1:0]      operand_a_r, operand_b_r;
  logic [RegAddrWidth-1:0] dest_r;
  logic                    start_sgnj, start_class, start_cmp;

  // Unit returns
  logic                    sgnj_valid, class_valid, cmp_valid;
  logic [FpWidth-1:0]      sgnj_result, cmp_result;
  logic [ClassWidth-1:0]   class_result;
  logic [RegAddrWidth-1:0] sgnj_dest, class_dest, cmp_dest;
  logic                    cmp_to_int, cmp_busy;
  fp_flags_t               cmp_flags;

  // ============================================================
  // Issue, three units, result select
  // ============================================================
  fpu_issue u_issue (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_operation(i_operation),
    .i_operand_a(i_operand_a), .i_operand_b(i_operand_b), .i_dest_reg(i_dest_reg),
    .i_result_valid(o_valid), .o_operation(op_r), .o_operand_a(operand_a_r),
    .o_operand_b(operand_b_r), .o_dest_reg(dest_r), .o_start_sgnj(start_sgnj),
    .o_start_class(start_class), .o_start_cmp(start_cmp), .o_stall(o_stall)
  );

  fpu_sign_inject u_sign_inject (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start_sgnj), .i_operation(op_r),
    .i_operand_a(operand_a_r), .i_operand_b(operand_b_r), .i_dest_reg(dest_r),
    .o_valid(sgnj_valid), .o_result(sgnj_result), .o_dest_reg(sgnj_dest)
  );

  fpu_classify u_classify (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start_class), .i_operand_a(operand_a_r),
    .i_dest_reg(dest_r), .o_valid(class_valid), .o_result(class_result),
    .o_dest_reg(class_dest)
  );

  fpu_compare u_compare (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start_cmp), .i_operation(op_r),
    .i_operand_a(operand_a_r), .i_operand_b(operand_b_r), .i_dest_reg(dest_r),
    .o_valid(cmp_valid), .o_result(cmp_result), .o_to_int(cmp_to_int),
    .o_flags(cmp_flags), .o_busy(cmp_busy), .o_dest_reg(cmp_dest)
  );

  fpu_result_mux u_result_mux (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_sgnj_valid(sgnj_valid), .i_sgnj_result(sgnj_result), .i_sgnj_dest(sgnj_dest),
    .i_class_valid(class_valid), .i_class_result(class_result),
    .i_class_dest(class_dest),
    .i_cmp_valid(cmp_valid), .i_cmp_result(cmp_result), .i_cmp_dest(cmp_dest),
    .i_cmp_to_int(cmp_to_int), .i_cmp_flags(cmp_flags),
    .o_valid(o_valid), .o_result(o_result), .o_flags(o_flags),
    .o_dest_reg(o_dest_reg), .o_result_to_int(o_result_to_int)
  );

  // Only compare spans more than one unit cycle
  assign o_inflight_valid = cmp_busy;
  assign o_inflight_dest = cmp_dest;

endmodule : fpu_top
